// File: common/vita_pkg.sv
package vita_pkg;

   localparam int WORD_W      = 36;
   localparam int SAMPLE_W    = 32;
   localparam int TIME_W      = 64;
   localparam int LEN_W       = 16;
   localparam int MAX_LANES   = 4;
   localparam int LANE_W      = $clog2(MAX_LANES);
   localparam int LINE_FLAG_W = 5;  // seqnum_err, has_secs, sob, eob, eop
   localparam int LINE_W      = MAX_LANES * SAMPLE_W + LINE_FLAG_W + TIME_W;
   localparam int FIFO_DEPTH  = 16;
   localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

   localparam logic [7:0] SETTING_ADDR = 8'd0;

   // vita-49 header fields
   localparam int HDR_SID_HI  = 31;
   localparam int HDR_SID_LO  = 28;
   localparam int HDR_CID_BIT = 27;
   localparam int HDR_TRL_BIT = 26;
   localparam int HDR_SOB_BIT = 25;
   localparam int HDR_EOB_BIT = 24;
   localparam int HDR_TSI_HI  = 23;
   localparam int HDR_TSI_LO  = 22;
   localparam int HDR_TSF_HI  = 21;
   localparam int HDR_TSF_LO  = 20;
   localparam int HDR_SEQ_HI  = 19;
   localparam int HDR_SEQ_LO  = 16;
   localparam int HDR_LEN_HI  = 15;
   localparam int HDR_LEN_LO  = 0;
   localparam int EOF_BIT     = 33;

   localparam logic [3:0] SID_TYPE_WITH_ID = 4'b0001;  // data packet with stream id

   typedef logic [WORD_W-1:0]              vita_word_t;
   typedef logic [LEN_W-1:0]               vita_len_t;
   typedef logic [SAMPLE_W-1:0]            vita_sample_t;
   typedef logic [TIME_W-1:0]              vita_time_t;
   typedef logic [LINE_W-1:0]              vita_line_t;
   typedef logic [LANE_W-1:0]              vita_numchan_t;
   typedef logic [LANE_W-1:0]              vita_lane_t;
   typedef logic [HDR_SEQ_HI-HDR_SEQ_LO:0] vita_seq_t;
   typedef logic [FIFO_PTR_W-1:0]          vita_fifo_ptr_t;
   typedef logic [FIFO_PTR_W:0]            vita_fifo_cnt_t;

   typedef enum logic [3:0] {
      HEADER,
      STREAMID,
      CLASSID,
      CLASSID2,
      SECS,
      TICS,
      TICS2,
      PAYLOAD,
      STORE,
      TRAILER
   } vita_state_e;

endpackage

// File: common/vita_ctl_if.sv
`timescale 1ns/1ps

interface vita_ctl_if;
   logic                 hdr_stb;
   logic                 secs_stb;
   logic                 tics2_stb;
   logic                 payload_stb;
   logic                 store_stb;
   vita_pkg::vita_len_t  payload_len;  // valid with hdr_stb
   vita_pkg::vita_lane_t lane;
   logic                 line_done;
   logic                 eop;          // valid in STORE

   modport fsm (output hdr_stb, secs_stb, tics2_stb, payload_stb, store_stb, payload_len,
                input  line_done, eop);

   modport counter (input  hdr_stb, payload_stb, store_stb, payload_len,
                    output lane, line_done, eop);

   modport builder (input hdr_stb, secs_stb, tics2_stb, payload_stb, store_stb, lane, eop);
endinterface

// File: rtl/setting_reg.sv
`timescale 1ns/1ps

module setting_reg (
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    set_stb_i,
   input  logic [7:0]              set_addr_i,
   input  logic [31:0]             set_data_i,
   output vita_pkg::vita_numchan_t numchan_o
);

   // channel count minus one, lives in the low data bits
   always_ff @(posedge clk)
   begin
      if (rst_i)
         numchan_o <= '0;
      else if (set_stb_i && (set_addr_i == vita_pkg::SETTING_ADDR))
         numchan_o <= set_data_i[vita_pkg::LANE_W-1:0];
   end

endmodule

// File: rtl/fifo_short.sv
`timescale 1ns/1ps

module fifo_short (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 clear_i,
   input  logic                 wr_i,
   input  vita_pkg::vita_line_t wr_data_i,
   input  logic                 rd_dst_rdy_i,
   output logic                 space_o,
   output vita_pkg::vita_line_t rd_data_o,
   output logic                 rd_src_rdy_o,
   output logic [15:0]          occupied_o,
   output logic                 full_o,
   output logic                 empty_o
);

   vita_pkg::vita_line_t     mem [vita_pkg::FIFO_DEPTH];
   vita_pkg::vita_fifo_ptr_t wr_ptr_q;
   vita_pkg::vita_fifo_ptr_t rd_ptr_q;
   vita_pkg::vita_fifo_cnt_t count_q;
   vita_pkg::vita_fifo_cnt_t count_left;
   logic                     do_wr;
   logic                     do_rd;

   assign do_wr      = wr_i & ~full_o;
   assign do_rd      = rd_src_rdy_o & rd_dst_rdy_i;
   assign count_left = count_q - vita_pkg::vita_fifo_cnt_t'(do_rd);  // entries kept after a read

   assign full_o     = (count_q == vita_pkg::vita_fifo_cnt_t'(vita_pkg::FIFO_DEPTH));
   assign empty_o    = (count_q == '0);
   assign space_o    = ~full_o;
   assign occupied_o = 16'(count_q);
   assign rd_data_o  = mem[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         count_q      <= '0;
         rd_src_rdy_o <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q      <= count_left + vita_pkg::vita_fifo_cnt_t'(do_wr);
         rd_src_rdy_o <= (count_left != '0);  // a new entry shows one edge after its write
      end
   end

endmodule

// File: vita_deframer/vita_deframer_fsm.sv
`timescale 1ns/1ps

module vita_deframer_fsm (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 clear_i,
   input  vita_pkg::vita_word_t data_i,
   input  logic                 src_rdy_i,
   input  logic                 fifo_space_i,
   output logic                 dst_rdy_o,
   vita_ctl_if.fsm              ctl
);

   vita_pkg::vita_state_e state_q;
   vita_pkg::vita_state_e state_d;
   logic                  accept;
   logic                  dec_sid;
   logic                  dec_cid;
   logic                  dec_secs;
   logic                  dec_tics;
   logic                  dec_trl;
   logic                  cid_q;
   logic                  secs_q;
   logic                  tics_q;
   logic                  trl_q;
   vita_pkg::vita_len_t   hdr_words;

   // next optional field in header order, payload when none is left
   function automatic vita_pkg::vita_state_e first_field(input logic sid, input logic cid,
                                                         input logic secs, input logic tics);
      if (sid)
         return vita_pkg::STREAMID;
      else if (cid)
         return vita_pkg::CLASSID;
      else if (secs)
         return vita_pkg::SECS;
      else if (tics)
         return vita_pkg::TICS;
      else
         return vita_pkg::PAYLOAD;
   endfunction

   assign dec_sid  = (data_i[vita_pkg::HDR_SID_HI:vita_pkg::HDR_SID_LO] ==
                      vita_pkg::SID_TYPE_WITH_ID);
   assign dec_cid  = data_i[vita_pkg::HDR_CID_BIT];
   assign dec_secs = |data_i[vita_pkg::HDR_TSI_HI:vita_pkg::HDR_TSI_LO];
   assign dec_tics = |data_i[vita_pkg::HDR_TSF_HI:vita_pkg::HDR_TSF_LO];
   assign dec_trl  = data_i[vita_pkg::HDR_TRL_BIT];

   assign hdr_words = vita_pkg::vita_len_t'(1)
                    + vita_pkg::vita_len_t'(dec_sid)
                    + vita_pkg::vita_len_t'({dec_cid, 1'b0})
                    + vita_pkg::vita_len_t'(dec_secs)
                    + vita_pkg::vita_len_t'({dec_tics, 1'b0})
                    + vita_pkg::vita_len_t'(dec_trl);

   assign dst_rdy_o = (state_q != vita_pkg::STORE);  // STORE is the back-pressure hold
   assign accept    = src_rdy_i & dst_rdy_o;

   assign ctl.hdr_stb     = accept & (state_q == vita_pkg::HEADER);
   assign ctl.secs_stb    = accept & (state_q == vita_pkg::SECS);
   assign ctl.tics2_stb   = accept & (state_q == vita_pkg::TICS2);
   assign ctl.payload_stb = accept & (state_q == vita_pkg::PAYLOAD);
   assign ctl.store_stb   = (state_q == vita_pkg::STORE) & fifo_space_i;
   assign ctl.payload_len = data_i[vita_pkg::HDR_LEN_HI:vita_pkg::HDR_LEN_LO] - hdr_words;

   always_comb
   begin
      state_d = state_q;
      if (state_q == vita_pkg::STORE)
      begin
         if (fifo_space_i)
         begin
            if (!ctl.eop)
               state_d = vita_pkg::PAYLOAD;
            else if (trl_q)
               state_d = vita_pkg::TRAILER;
            else
               state_d = vita_pkg::HEADER;
         end
      end
      else if (accept)
      begin
         case (state_q)
            vita_pkg::HEADER:   state_d = first_field(dec_sid, dec_cid, dec_secs, dec_tics);
            vita_pkg::STREAMID: state_d = first_field(1'b0, cid_q, secs_q, tics_q);
            vita_pkg::CLASSID:  state_d = vita_pkg::CLASSID2;
            vita_pkg::CLASSID2: state_d = first_field(1'b0, 1'b0, secs_q, tics_q);
            vita_pkg::SECS:     state_d = first_field(1'b0, 1'b0, 1'b0, tics_q);
            vita_pkg::TICS:     state_d = vita_pkg::TICS2;
            vita_pkg::TICS2:    state_d = vita_pkg::PAYLOAD;
            vita_pkg::PAYLOAD:
            begin
               if (ctl.line_done)
                  state_d = vita_pkg::STORE;
            end
            vita_pkg::TRAILER:  state_d = vita_pkg::HEADER;  // trailer dropped
            default:            state_d = vita_pkg::HEADER;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         state_q <= vita_pkg::HEADER;
         cid_q   <= 1'b0;
         secs_q  <= 1'b0;
         tics_q  <= 1'b0;
         trl_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (ctl.hdr_stb)
         begin
            cid_q  <= dec_cid;
            secs_q <= dec_secs;
            tics_q <= dec_tics;
            trl_q  <= dec_trl;
         end
      end
   end

endmodule

// File: vita_deframer/vita_len_counter.sv
`timescale 1ns/1ps

module vita_len_counter (
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    clear_i,
   input  vita_pkg::vita_numchan_t numchan_i,
   input  logic                    eof_i,
   vita_ctl_if.counter             ctl
);

   vita_pkg::vita_len_t  remain_q;    // payload words still to come
   vita_pkg::vita_lane_t lane_q;
   logic                 eof_seen_q;

   assign ctl.lane      = lane_q;
   assign ctl.line_done = (lane_q == numchan_i);
   assign ctl.eop       = (remain_q == '0) | eof_seen_q;

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         remain_q   <= '0;
         lane_q     <= '0;
         eof_seen_q <= 1'b0;
      end
      else if (ctl.hdr_stb)
      begin
         remain_q   <= ctl.payload_len;
         lane_q     <= '0;
         eof_seen_q <= 1'b0;
      end
      else if (ctl.payload_stb)
      begin
         remain_q <= remain_q - 1'b1;
         if (ctl.line_done)
            lane_q <= '0;
         else
            lane_q <= lane_q + 1'b1;
         if (eof_i)
            eof_seen_q <= 1'b1;  // held until the line is stored
      end
      else if (ctl.store_stb)
         eof_seen_q <= 1'b0;
   end

endmodule

// File: vita_deframer/vita_line_builder.sv
`timescale 1ns/1ps

module vita_line_builder (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 clear_i,
   input  vita_pkg::vita_word_t data_i,
   output vita_pkg::vita_line_t line_o,
   vita_ctl_if.builder          ctl
);

   vita_pkg::vita_sample_t lane_q [vita_pkg::MAX_LANES];
   vita_pkg::vita_time_t   time_q;
   vita_pkg::vita_seq_t    seq_q;
   vita_pkg::vita_seq_t    seq_in;
   logic                   sob_in;
   logic                   seq_err_q;
   logic                   has_secs_q;
   logic                   sob_q;
   logic                   eob_q;

   assign seq_in = data_i[vita_pkg::HDR_SEQ_HI:vita_pkg::HDR_SEQ_LO];
   assign sob_in = data_i[vita_pkg::HDR_SOB_BIT];

   // packet flags, repeated on every line
   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         seq_q      <= '0;
         seq_err_q  <= 1'b0;
         has_secs_q <= 1'b0;
         sob_q      <= 1'b0;
         eob_q      <= 1'b0;
      end
      else if (ctl.hdr_stb)
      begin
         seq_q      <= seq_in;
         seq_err_q  <= ~sob_in & (seq_in != vita_pkg::vita_seq_t'(seq_q + 1'b1));  // wraps at 16
         has_secs_q <= |data_i[vita_pkg::HDR_TSI_HI:vita_pkg::HDR_TSI_LO];
         sob_q      <= sob_in;
         eob_q      <= data_i[vita_pkg::HDR_EOB_BIT];
      end
   end

   // secs in the high half, low tics word in the low half
   always_ff @(posedge clk)
   begin
      if (ctl.hdr_stb || ctl.store_stb)
         time_q <= '0;  // first line only
      else if (ctl.secs_stb)
         time_q[vita_pkg::TIME_W-1:vita_pkg::TIME_W/2] <= data_i[vita_pkg::SAMPLE_W-1:0];
      else if (ctl.tics2_stb)
         time_q[vita_pkg::TIME_W/2-1:0] <= data_i[vita_pkg::SAMPLE_W-1:0];
   end

   always_ff @(posedge clk)
   begin
      if (ctl.payload_stb)
         lane_q[ctl.lane] <= data_i[vita_pkg::SAMPLE_W-1:0];
   end

   assign line_o = {lane_q[3], lane_q[2], lane_q[1], lane_q[0],
                    seq_err_q, has_secs_q, sob_q, eob_q, ctl.eop,
                    time_q};

endmodule

// File: vita_deframer/vita_tx_deframer.sv
`timescale 1ns/1ps

module vita_tx_deframer (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 clear_i,
   input  logic                 set_stb_i,
   input  logic [7:0]           set_addr_i,
   input  logic [31:0]          set_data_i,
   input  vita_pkg::vita_word_t data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   output vita_pkg::vita_line_t sample_o,
   output logic                 sample_src_rdy_o,
   input  logic                 sample_dst_rdy_i,
   output logic [15:0]          fifo_occupied_o,
   output logic                 fifo_full_o,
   output logic                 fifo_empty_o
);

   vita_pkg::vita_numchan_t numchan;
   vita_pkg::vita_line_t    line;
   logic                    fifo_space;

   vita_ctl_if ctl_if ();

   setting_reg setting_reg_i (
      .clk        (clk),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .numchan_o  (numchan)
   );

   vita_deframer_fsm vita_deframer_fsm_i (
      .clk          (clk),
      .rst_i        (rst_i),
      .clear_i      (clear_i),
      .data_i       (data_i),
      .src_rdy_i    (src_rdy_i),
      .fifo_space_i (fifo_space),
      .dst_rdy_o    (dst_rdy_o),
      .ctl          (ctl_if.fsm)
   );

   vita_len_counter vita_len_counter_i (
      .clk       (clk),
      .rst_i     (rst_i),
      .clear_i   (clear_i),
      .numchan_i (numchan),
      .eof_i     (data_i[vita_pkg::EOF_BIT]),
      .ctl       (ctl_if.counter)
   );

   vita_line_builder vita_line_builder_i (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .data_i  (data_i),
      .line_o  (line),
      .ctl     (ctl_if.builder)
   );

   fifo_short fifo_short_i (
      .clk          (clk),
      .rst_i        (rst_i),
      .clear_i      (clear_i),
      .wr_i         (ctl_if.store_stb),
      .wr_data_i    (line),
      .rd_dst_rdy_i (sample_dst_rdy_i),
      .space_o      (fifo_space),
      .rd_data_o    (sample_o),
      .rd_src_rdy_o (sample_src_rdy_o),
      .occupied_o   (fifo_occupied_o),
      .full_o       (fifo_full_o),
      .empty_o      (fifo_empty_o)
   );

endmodule

// File: dv/vita_tx_deframer_assertions.sv
`timescale 1ns/1ps

module vita_tx_deframer_assertions (
   input logic                 clk,
   input logic                 rst_i,
   input logic                 clear_i,
   input vita_pkg::vita_line_t sample_o,
   input logic                 sample_src_rdy_o,
   input logic                 sample_dst_rdy_i,
   input logic [15:0]          fifo_occupied_o,
   input logic                 fifo_full_o,
   input logic                 fifo_empty_o
);

   full_not_empty: assert property (@(posedge clk) disable iff (rst_i)
                                    !(fifo_full_o && fifo_empty_o))
      else $error("fifo_full_o and fifo_empty_o high together");

   occupied_in_range: assert property (@(posedge clk) disable iff (rst_i)
                                       fifo_occupied_o <= 16'(vita_pkg::FIFO_DEPTH))
      else $error("fifo_occupied_o above the FIFO depth");

   // a waiting line must not move
   hold_when_stalled: assert property (@(posedge clk) disable iff (rst_i || clear_i)
                                       sample_src_rdy_o && !sample_dst_rdy_i
                                       |=> sample_src_rdy_o && $stable(sample_o))
      else $error("output line changed while stalled");

   no_valid_in_reset: assert property (@(posedge clk) rst_i |=> !sample_src_rdy_o)
      else $error("sample_src_rdy_o high during reset");

endmodule

bind vita_tx_deframer vita_tx_deframer_assertions vita_tx_deframer_assertions_i (.*);

// File: dv/tb_vita_tx_deframer.sv
`timescale 1ns/1ps

module tb_vita_tx_deframer;

   logic                 clk;
   logic                 rst_i;
   logic                 clear_i;
   logic                 set_stb_i;
   logic [7:0]           set_addr_i;
   logic [31:0]          set_data_i;
   vita_pkg::vita_word_t data_i;
   logic                 src_rdy_i;
   logic                 dst_rdy_o;
   vita_pkg::vita_line_t sample_o;
   logic                 sample_src_rdy_o;
   logic                 sample_dst_rdy_i;
   logic [15:0]          fifo_occupied_o;
   logic                 fifo_full_o;
   logic                 fifo_empty_o;

   vita_pkg::vita_line_t exp_q [$];  // expected lines, oldest first
   int                   nch_q [$];  // lanes in use per expected line
   int                   numchan;
   vita_pkg::vita_seq_t  prev_seq;
   bit                   stall;      // output held off by the monitor
   int                   max_wait = 2000;

   vita_tx_deframer vita_tx_deframer_i (.*);

   always #5 clk = ~clk;

   task automatic stop_on_error(input string msg);
      begin
         $display("%s", msg);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                              input string what);
      begin
         if (got !== expected)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
                                    $time, what, got, expected));
      end
   endtask

   function automatic vita_pkg::vita_sample_t lane_of(input vita_pkg::vita_line_t line,
                                                      input int k);
      return line[vita_pkg::TIME_W + vita_pkg::LINE_FLAG_W + k * vita_pkg::SAMPLE_W +:
                  vita_pkg::SAMPLE_W];
   endfunction

   // pops one expected line, unused lanes are not compared
   task automatic compare_line();
      vita_pkg::vita_line_t expected;
      int                   nch;
      begin
         if (exp_q.size() == 0)
            stop_on_error("the DUT delivered a line that was not expected");
         else
         begin
            expected = exp_q.pop_front();
            nch      = nch_q.pop_front();
            for (int k = 0; k < nch; k++)
               check_value(64'(lane_of(sample_o, k)), 64'(lane_of(expected, k)),
                           $sformatf("sample lane %0d", k));
            check_value(64'(sample_o[vita_pkg::TIME_W +: vita_pkg::LINE_FLAG_W]),
                        64'(expected[vita_pkg::TIME_W +: vita_pkg::LINE_FLAG_W]),
                        "flags seqnum_err has_secs sob eob eop");
            check_value(sample_o[vita_pkg::TIME_W-1:0], expected[vita_pkg::TIME_W-1:0],
                        "send time");
         end
      end
   endtask

   // output side, random stalls unless held
   always @(negedge clk)
   begin
      sample_dst_rdy_i = !stall && ($urandom % 3 != 0);
      if (sample_src_rdy_o && sample_dst_rdy_i)
         compare_line();
   end

   // called on a falling edge, returns on the falling edge after acceptance
   task automatic send_word(input vita_pkg::vita_word_t w);
      int gap;
      int waited;
      begin
         gap       = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
         src_rdy_i = 1'b0;
         repeat (gap) @(negedge clk);
         data_i    = w;
         src_rdy_i = 1'b1;
         waited    = 0;
         while (!dst_rdy_o)
         begin
            @(negedge clk);
            waited++;
            if (waited > max_wait)
               stop_on_error("timeout: the DUT did not accept an input word");
         end
         @(negedge clk);
         src_rdy_i = 1'b0;
      end
   endtask

   task automatic write_numchan(input int n);
      begin
         numchan    = n;
         set_stb_i  = 1'b1;
         set_addr_i = vita_pkg::SETTING_ADDR;
         set_data_i = ($urandom & 32'hffff_fffc) | 32'(n);
         @(negedge clk);
         set_addr_i = 8'(vita_pkg::SETTING_ADDR + 1);  // other register, ignored
         set_data_i = $urandom;
         @(negedge clk);
         set_stb_i = 1'b0;
      end
   endtask

   // fields: trailer, tics, secs, class id, stream id (bit 0)
   task automatic send_packet(input int nlines, input logic [4:0] fields, input bit allow_eof,
                              input bit measure);
      vita_pkg::vita_sample_t samples [vita_pkg::MAX_LANES];
      vita_pkg::vita_time_t   send_time;
      vita_pkg::vita_seq_t    seq;
      vita_pkg::vita_len_t    len;
      logic [1:0]             tsi;
      logic [1:0]             tsf;
      logic                   sob;
      logic                   eob;
      logic                   seq_err;
      int                     nch;
      int                     eof_line;
      int                     eof_lane;
      int                     lines_out;
      int                     waited;
      begin
         nch      = numchan + 1;
         tsi      = fields[2] ? 2'(1 + $urandom % 3) : 2'd0;
         tsf      = fields[3] ? 2'(1 + $urandom % 3) : 2'd0;
         sob      = ($urandom % 4 == 0);
         eob      = ($urandom % 4 == 0);
         seq      = ($urandom % 4 == 0) ? 4'($urandom) : 4'(prev_seq + 1'b1);
         seq_err  = !sob && (seq != 4'(prev_seq + 1'b1));
         prev_seq = seq;
         len      = 16'(1 + fields[0] + 2 * fields[1] + fields[2] + 2 * fields[3] + fields[4]
                        + nlines * nch);
         eof_line = -1;
         eof_lane = 0;
         if (allow_eof && ($urandom % 4 == 0))
         begin
            eof_line = $urandom % nlines;  // packet cut short after this line
            eof_lane = $urandom % nch;
         end
         lines_out = (eof_line >= 0) ? eof_line + 1 : nlines;

         send_word({2'b00, 1'b0, 1'b1, fields[0] ? 4'b0001 : 4'b0000, fields[1], fields[4],
                    sob, eob, tsi, tsf, seq, len});
         if (fields[0])
            send_word(36'($urandom));
         if (fields[1])
         begin
            send_word(36'($urandom));
            send_word(36'($urandom));
         end
         send_time = '0;
         if (fields[2])
         begin
            send_time[63:32] = $urandom;
            send_word({4'h0, send_time[63:32]});
         end
         if (fields[3])
         begin
            send_word(36'($urandom));  // upper tics, dropped
            send_time[31:0] = $urandom;
            send_word({4'h0, send_time[31:0]});
         end

         for (int l = 0; l < lines_out; l++)
         begin
            for (int k = 0; k < vita_pkg::MAX_LANES; k++)
               samples[k] = $urandom;
            exp_q.push_back({samples[3], samples[2], samples[1], samples[0],
                             seq_err, (|tsi), sob, eob, 1'(l == lines_out - 1),
                             ((l == 0) ? send_time : 64'd0)});
            nch_q.push_back(nch);
            for (int k = 0; k < nch; k++)
               send_word({2'b00, 1'(l == eof_line && k == eof_lane), 1'b0, samples[k]});
            if (measure && (l == lines_out - 1))
            begin
               waited = 0;
               while (!sample_src_rdy_o)
               begin
                  @(negedge clk);
                  waited++;
                  if (waited > max_wait)
                     stop_on_error("timeout: sample_src_rdy_o never rose");
               end
               check_value(64'(waited), 64'd2, "cycles from last payload word to output");
            end
         end
         if (fields[4])
            send_word({2'b00, 1'b1, 1'b0, 32'($urandom)});  // trailer
      end
   endtask

   task automatic wait_drained();
      int waited;
      begin
         waited = 0;
         while (exp_q.size() != 0 || !fifo_empty_o)
         begin
            @(negedge clk);
            waited++;
            if (waited > max_wait)
               stop_on_error("timeout: expected lines did not all come out");
         end
      end
   endtask

   // 16 lines fill the FIFO, the 17th waits in STORE
   task automatic fill_fifo();
      int lines;
      int n;
      int waited;
      begin
         wait_drained();
         stall = 1'b1;
         lines = 0;
         while (lines < vita_pkg::FIFO_DEPTH + 1)
         begin
            n = 1 + $urandom % 3;
            if (n > vita_pkg::FIFO_DEPTH + 1 - lines)
               n = vita_pkg::FIFO_DEPTH + 1 - lines;
            send_packet(n, 5'($urandom) & 5'b01111, 1'b0, 1'b0);
            lines += n;
         end
         waited = 0;
         while (!fifo_full_o)
         begin
            @(negedge clk);
            waited++;
            if (waited > max_wait)
               stop_on_error("timeout: fifo_full_o never rose under a stalled output");
         end
         @(negedge clk);
         check_value(64'(dst_rdy_o), 64'd0, "dst_rdy_o with a full FIFO");
         check_value(64'(fifo_occupied_o), 64'(vita_pkg::FIFO_DEPTH), "fifo_occupied_o");
         stall = 1'b0;
         wait_drained();
      end
   endtask

   task automatic clear_between_packets();
      begin
         stall = 1'b1;
         send_packet(1 + $urandom % 3, 5'($urandom), 1'b1, 1'b0);
         send_packet(1 + $urandom % 3, 5'($urandom), 1'b1, 1'b0);
         repeat (3) @(negedge clk);
         check_value(64'(fifo_empty_o), 64'd0, "fifo_empty_o before clear");
         clear_i = 1'b1;
         @(negedge clk);
         clear_i = 1'b0;
         check_value(64'(fifo_empty_o), 64'd1, "fifo_empty_o after clear");
         check_value(64'(fifo_occupied_o), 64'd0, "fifo_occupied_o after clear");
         check_value(64'(dst_rdy_o), 64'd1, "dst_rdy_o after clear");
         check_value(64'(sample_src_rdy_o), 64'd0, "sample_src_rdy_o after clear");
         exp_q.delete();  // cleared lines are gone
         nch_q.delete();
         prev_seq = '0;
         stall    = 1'b0;
      end
   endtask

   initial
   begin
      clk              = 1'b0;
      rst_i            = 1'b1;
      clear_i          = 1'b0;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      data_i           = '0;
      src_rdy_i        = 1'b0;
      sample_dst_rdy_i = 1'b0;
      stall            = 1'b0;
      prev_seq         = '0;
      numchan          = 0;
      void'($urandom(85));
      repeat (16) @(negedge clk);
      rst_i = 1'b0;

      for (int r = 0; r < 6; r++)
      begin
         wait_drained();
         write_numchan((r < 4) ? r : int'($urandom % 4));
         send_packet(1, 5'($urandom), 1'b0, 1'b1);  // idle FIFO latency
         for (int p = 0; p < 32; p++)
            send_packet(1 + $urandom % 4, 5'(p), 1'b1, 1'b0);
         fill_fifo();
         clear_between_packets();
      end
      wait_drained();
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: src.f
common/vita_pkg.sv
common/vita_ctl_if.sv
rtl/setting_reg.sv
rtl/fifo_short.sv
vita_deframer/vita_deframer_fsm.sv
vita_deframer/vita_len_counter.sv
vita_deframer/vita_line_builder.sv
vita_deframer/vita_tx_deframer.sv
dv/vita_tx_deframer_assertions.sv
dv/tb_vita_tx_deframer.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_vita_tx_deframer
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported an error"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
